/* logic/fe_pkg.sv */
/* Shared widths, opcodes and instruction word views for the front end.
   Imported by every front-end module that decodes or carries addresses. */
package fe_pkg;

  ////////////////////////////////////////
  // Widths
  ////////////////////////////////////////

  // Data and address width
  localparam int XLEN   = 32;
  // Register file address
  localparam int REG_AW = 5;
  // CSR address, same bits as the I-type immediate
  localparam int CSR_AW = 12;

  ////////////////////////////////////////
  // Opcodes and constants
  ////////////////////////////////////////

  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

  // ADDI x0,x0,0
  localparam logic [XLEN-1:0] INSTR_NOP = 32'h0000_0013;

  ////////////////////////////////////////
  // Instruction formats
  ////////////////////////////////////////

  typedef struct packed {
    logic [6:0]        funct7;
    logic [REG_AW-1:0] rs2;
    logic [REG_AW-1:0] rs1;
    logic [2:0]        funct3;
    logic [REG_AW-1:0] rd;
    logic [6:0]        opcode;
  } insn_r_t;

  typedef struct packed {
    logic [CSR_AW-1:0] imm;
    logic [REG_AW-1:0] rs1;
    logic [2:0]        funct3;
    logic [REG_AW-1:0] rd;
    logic [6:0]        opcode;
  } insn_i_t;

  // Branch offset bits are scattered around rs1/rs2
  typedef struct packed {
    logic              imm12;
    logic [5:0]        imm10_5;
    logic [REG_AW-1:0] rs2;
    logic [REG_AW-1:0] rs1;
    logic [2:0]        funct3;
    logic [3:0]        imm4_1;
    logic              imm11;
    logic [6:0]        opcode;
  } insn_b_t;

  // Jump offset, sign bit first
  typedef struct packed {
    logic              imm20;
    logic [9:0]        imm10_1;
    logic              imm11;
    logic [7:0]        imm19_12;
    logic [REG_AW-1:0] rd;
    logic [6:0]        opcode;
  } insn_j_t;

  // One fetched word, several decodings
  typedef union packed {
    insn_r_t r;
    insn_i_t i;
    insn_b_t b;
    insn_j_t j;
  } insn_u;

endpackage

/* logic/fe_pc_gen.sv */
/* Fetch program counter and next-address select for the instruction memory.
   Drives the fetch address combinationally and flags the redirect bubble. */
`timescale 1ns/1ps

module fe_pc_gen import fe_pkg::*; #(
  parameter logic [XLEN-1:0] PC_INIT = 32'h200
) (
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            id_stall_i,
  input  logic            st_flush_i,
  input  logic            bu_flush_i,
  input  logic [XLEN-1:0] st_nxt_pc_i,
  input  logic [XLEN-1:0] bu_nxt_pc_i,
  input  logic            pd_latch_nxt_pc_i,
  input  logic [XLEN-1:0] pd_nxt_pc_i,
  output logic [XLEN-1:0] next_pc_o,
  output logic [XLEN-1:0] if_pc_o,
  output logic            if_bubble_o
);

  // Word aligned fetch only
  localparam logic [XLEN-1:0] ADR_MASK = {{(XLEN-2){1'b1}}, 2'b00};

  logic [XLEN-1:0] next_pc_raw;
  logic [XLEN-1:0] next_pc;
  logic [XLEN-1:0] if_pc_q;
  logic            if_bubble_q;
  logic            redirect;

  // Any source that breaks the sequential stream
  assign redirect = st_flush_i | bu_flush_i | pd_latch_nxt_pc_i;

  ////////////////////////////////////////
  // Next fetch address
  ////////////////////////////////////////

  always_comb begin
    if (st_flush_i) begin
      next_pc_raw = st_nxt_pc_i;
    end else if (bu_flush_i) begin
      next_pc_raw = bu_nxt_pc_i;
    end else if (pd_latch_nxt_pc_i) begin
      next_pc_raw = pd_nxt_pc_i;
    end else if (id_stall_i || if_bubble_q) begin
      // Hold, or re-present the target while the bubble drains
      next_pc_raw = if_pc_q;
    end else begin
      next_pc_raw = if_pc_q + XLEN'(4);
    end
  end

  assign next_pc = next_pc_raw & ADR_MASK;

  ////////////////////////////////////////
  // Fetch register
  ////////////////////////////////////////

  // Bubble marks the fetch slot invalid after reset or a redirect
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      if_pc_q     <= PC_INIT & ADR_MASK;
      if_bubble_q <= 1'b1;
    end else begin
      if_pc_q     <= next_pc;
      if_bubble_q <= redirect | (id_stall_i & if_bubble_q);
    end
  end

  assign next_pc_o   = next_pc;
  assign if_pc_o     = if_pc_q;
  assign if_bubble_o = if_bubble_q;

endmodule

/* logic/fe_bht.sv */
/* Branch history table of 2-bit saturating counters with global history.
   Looked up on the next fetch address, trained from resolved branches. */
`timescale 1ns/1ps

module fe_bht import fe_pkg::*; #(
  parameter int BHT_IDX_BITS = 6,
  parameter int HISTORY_BITS = 2
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    id_stall_i,
  input  logic [XLEN-1:0]         next_pc_i,
  input  logic                    upd_valid_i,
  input  logic [XLEN-1:0]         upd_pc_i,
  input  logic                    upd_taken_i,
  output logic [1:0]              bp_predict_o,
  output logic [HISTORY_BITS-1:0] bp_history_o
);

  localparam int BHT_DEPTH = 2 ** BHT_IDX_BITS;

  logic [1:0]              cnt_q [BHT_DEPTH];
  logic [HISTORY_BITS-1:0] ghr_q;
  logic [BHT_IDX_BITS-1:0] rd_idx;
  logic [BHT_IDX_BITS-1:0] wr_idx;
  logic [1:0]              wr_cnt;

  ////////////////////////////////////////
  // Indexing
  ////////////////////////////////////////

  // Word address bits hashed with history
  assign rd_idx = next_pc_i[BHT_IDX_BITS+1:2] ^ BHT_IDX_BITS'(ghr_q);
  assign wr_idx = upd_pc_i[BHT_IDX_BITS+1:2] ^ BHT_IDX_BITS'(ghr_q);

  // Saturating step toward the resolved outcome
  always_comb begin
    wr_cnt = cnt_q[wr_idx];
    if (upd_taken_i && (wr_cnt != 2'b11)) begin
      wr_cnt = wr_cnt + 2'd1;
    end else if (!upd_taken_i && (wr_cnt != 2'b00)) begin
      wr_cnt = wr_cnt - 2'd1;
    end
  end

  ////////////////////////////////////////
  // Counters and history
  ////////////////////////////////////////

  // All entries start weakly not taken
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < BHT_DEPTH; i++) begin
        cnt_q[i] <= 2'b01;
      end
    end else if (upd_valid_i) begin
      cnt_q[wr_idx] <= wr_cnt;
    end
  end

  // Newest outcome enters at bit 0
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ghr_q <= '0;
    end else if (upd_valid_i) begin
      ghr_q <= {ghr_q[HISTORY_BITS-2:0], upd_taken_i};
    end
  end

  // Lookup result lines up with the fetch register
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      bp_predict_o <= 2'b00;
      bp_history_o <= '0;
    end else if (!id_stall_i) begin
      bp_predict_o <= cnt_q[rd_idx];
      bp_history_o <= ghr_q;
    end
  end

endmodule

/* logic/fe_predecode.sv */
/* Pre-decode stage between fetch and decode. Extracts operand addresses,
   resolves JAL and predicted branch targets and registers the word onward. */
`timescale 1ns/1ps

module fe_predecode import fe_pkg::*; #(
  parameter int HISTORY_BITS = 2
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    id_stall_i,
  input  logic                    st_flush_i,
  input  logic                    bu_flush_i,
  input  logic                    pipe_exception_i,
  input  logic [XLEN-1:0]         if_pc_i,
  input  insn_u                   if_insn_i,
  input  logic                    if_bubble_i,
  input  logic [1:0]              bp_predict_i,
  input  logic [HISTORY_BITS-1:0] bp_history_i,
  output logic                    pd_flush_o,
  output logic [REG_AW-1:0]       pd_rs1_o,
  output logic [REG_AW-1:0]       pd_rs2_o,
  output logic [CSR_AW-1:0]       pd_csr_reg_o,
  output logic [XLEN-1:0]         pd_pc_o,
  output insn_u                   pd_insn_o,
  output logic                    pd_bubble_o,
  output logic [1:0]              pd_bp_predict_o,
  output logic [HISTORY_BITS-1:0] pd_bp_history_o,
  output logic [XLEN-1:0]         pd_nxt_pc_o,
  output logic                    pd_latch_nxt_pc_o
);

  logic [20:0]     imm_j;
  logic [12:0]     imm_b;
  logic [XLEN-1:0] ext_j;
  logic [XLEN-1:0] ext_b;
  logic            is_jal;
  logic            taken;
  logic            taken_q;
  logic [1:0]      predicted;

  // Either flush source empties the stage
  assign pd_flush_o = st_flush_i | bu_flush_i;

  ////////////////////////////////////////
  // Operand fields
  ////////////////////////////////////////

  // Register file and CSR addresses, read early
  assign pd_rs1_o     = if_insn_i.r.rs1;
  assign pd_rs2_o     = if_insn_i.r.rs2;
  assign pd_csr_reg_o = if_insn_i.i.imm;

  ////////////////////////////////////////
  // Targets
  ////////////////////////////////////////

  // Reassemble scattered offsets, bit 0 always zero
  assign imm_j = {if_insn_i.j.imm20, if_insn_i.j.imm19_12, if_insn_i.j.imm11,
                  if_insn_i.j.imm10_1, 1'b0};
  assign imm_b = {if_insn_i.b.imm12, if_insn_i.b.imm11, if_insn_i.b.imm10_5,
                  if_insn_i.b.imm4_1, 1'b0};

  // Sign extension to full width
  assign ext_j = {{(XLEN-21){imm_j[20]}}, imm_j};
  assign ext_b = {{(XLEN-13){imm_b[12]}}, imm_b};

  assign is_jal      = (if_insn_i.r.opcode == OPC_JAL);
  assign pd_nxt_pc_o = if_pc_i + (is_jal ? ext_j : ext_b);

  ////////////////////////////////////////
  // Prediction and redirect strobe
  ////////////////////////////////////////

  // Bubbles never redirect
  always_comb begin
    taken     = 1'b0;
    predicted = 2'b00;
    if (!if_bubble_i) begin
      case (if_insn_i.r.opcode)
        OPC_JAL: begin
          taken     = 1'b1;
          predicted = 2'b10;
        end
        OPC_BRANCH: begin
          // Table MSB decides direction
          taken     = bp_predict_i[1];
          predicted = bp_predict_i;
        end
        default: begin
          taken     = 1'b0;
          predicted = 2'b00;
        end
      endcase
    end
  end

  // Edge detect, frozen during stall
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      taken_q <= 1'b0;
    end else if (!id_stall_i) begin
      taken_q <= taken;
    end
  end

  // One pulse per taken instruction
  assign pd_latch_nxt_pc_o = taken & ~taken_q & ~id_stall_i;

  ////////////////////////////////////////
  // Pipeline register
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pd_pc_o         <= '0;
      pd_insn_o       <= INSTR_NOP;
      pd_bp_predict_o <= 2'b00;
      pd_bp_history_o <= '0;
    end else if (!id_stall_i) begin
      pd_pc_o         <= if_pc_i;
      pd_insn_o       <= if_insn_i;
      pd_bp_predict_o <= predicted;
      pd_bp_history_o <= bp_history_i;
    end
  end

  // Flush and exception win over stall
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pd_bubble_o <= 1'b1;
    end else if (pd_flush_o || pipe_exception_i) begin
      pd_bubble_o <= 1'b1;
    end else if (!id_stall_i) begin
      pd_bubble_o <= if_bubble_i;
    end
  end

endmodule

/* logic/fe_top.sv */
/* Instruction front end top. Ties the PC generator, branch history table
   and pre-decode stage to the instruction memory and decode interfaces. */
`timescale 1ns/1ps

module fe_top import fe_pkg::*; #(
  parameter logic [XLEN-1:0] PC_INIT      = 32'h200,
  parameter int              BHT_IDX_BITS = 6,
  parameter int              HISTORY_BITS = 2
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic [XLEN-1:0]         imem_rdata_i,
  input  logic                    id_stall_i,
  input  logic                    st_flush_i,
  input  logic [XLEN-1:0]         st_nxt_pc_i,
  input  logic                    bu_flush_i,
  input  logic [XLEN-1:0]         bu_nxt_pc_i,
  input  logic                    pipe_exception_i,
  input  logic                    bht_upd_valid_i,
  input  logic [XLEN-1:0]         bht_upd_pc_i,
  input  logic                    bht_upd_taken_i,
  output logic [XLEN-1:0]         imem_adr_o,
  output logic                    pd_flush_o,
  output logic [XLEN-1:0]         pd_pc_o,
  output insn_u                   pd_insn_o,
  output logic                    pd_bubble_o,
  output logic [REG_AW-1:0]       pd_rs1_o,
  output logic [REG_AW-1:0]       pd_rs2_o,
  output logic [CSR_AW-1:0]       pd_csr_reg_o,
  output logic [1:0]              pd_bp_predict_o,
  output logic [HISTORY_BITS-1:0] pd_bp_history_o
);

  ////////////////////////////////////////
  // Internal nets
  ////////////////////////////////////////

  logic [XLEN-1:0]         next_pc;
  logic [XLEN-1:0]         if_pc;
  logic                    if_bubble;
  insn_u                   if_insn;
  logic [1:0]              bp_predict;
  logic [HISTORY_BITS-1:0] bp_history;
  logic [XLEN-1:0]         pd_nxt_pc;
  logic                    pd_latch_nxt_pc;

  // Memory data lines up with if_pc
  assign imem_adr_o = next_pc;
  assign if_insn    = imem_rdata_i;

  fe_pc_gen #(
    .PC_INIT (PC_INIT)
  ) u_pc_gen (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .id_stall_i        (id_stall_i),
    .st_flush_i        (st_flush_i),
    .bu_flush_i        (bu_flush_i),
    .st_nxt_pc_i       (st_nxt_pc_i),
    .bu_nxt_pc_i       (bu_nxt_pc_i),
    .pd_latch_nxt_pc_i (pd_latch_nxt_pc),
    .pd_nxt_pc_i       (pd_nxt_pc),
    .next_pc_o         (next_pc),
    .if_pc_o           (if_pc),
    .if_bubble_o       (if_bubble)
  );

  // Same next-fetch address as the memory
  fe_bht #(
    .BHT_IDX_BITS (BHT_IDX_BITS),
    .HISTORY_BITS (HISTORY_BITS)
  ) u_bht (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .id_stall_i   (id_stall_i),
    .next_pc_i    (next_pc),
    .upd_valid_i  (bht_upd_valid_i),
    .upd_pc_i     (bht_upd_pc_i),
    .upd_taken_i  (bht_upd_taken_i),
    .bp_predict_o (bp_predict),
    .bp_history_o (bp_history)
  );

  fe_predecode #(
    .HISTORY_BITS (HISTORY_BITS)
  ) u_predecode (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .id_stall_i        (id_stall_i),
    .st_flush_i        (st_flush_i),
    .bu_flush_i        (bu_flush_i),
    .pipe_exception_i  (pipe_exception_i),
    .if_pc_i           (if_pc),
    .if_insn_i         (if_insn),
    .if_bubble_i       (if_bubble),
    .bp_predict_i      (bp_predict),
    .bp_history_i      (bp_history),
    .pd_flush_o        (pd_flush_o),
    .pd_rs1_o          (pd_rs1_o),
    .pd_rs2_o          (pd_rs2_o),
    .pd_csr_reg_o      (pd_csr_reg_o),
    .pd_pc_o           (pd_pc_o),
    .pd_insn_o         (pd_insn_o),
    .pd_bubble_o       (pd_bubble_o),
    .pd_bp_predict_o   (pd_bp_predict_o),
    .pd_bp_history_o   (pd_bp_history_o),
    .pd_nxt_pc_o       (pd_nxt_pc),
    .pd_latch_nxt_pc_o (pd_latch_nxt_pc)
  );

endmodule

/* include/fe_tb_tests.svh */
/* Directed front-end tests, included inside the testbench top module.
   Each task starts at a falling edge and ends at one. */
`ifndef FE_TB_TESTS_SVH
`define FE_TB_TESTS_SVH

////////////////////////////////////////
// Sequential fetch after reset
////////////////////////////////////////

task automatic sequential_fetch();
  logic [XLEN-1:0] adr;
  for (int k = 0; k < 8; k++) begin
    if (k > 0) begin
      next_cycle();
    end
    #1;
    adr = RESET_PC + XLEN'(4 * k);
    check_pc("seq fetch address", adr, imem_adr_o);
    // Fetch holds the previous address and decode the one before
    if (k >= 1) begin
      check_fields("seq fields", mem_word(adr - 32'd4));
    end
    if (k >= 2) begin
      check_stage("seq decode", adr - 32'd8);
    end else begin
      check_flag("seq reset bubble", 1'b1, pd_bubble_o);
    end
  end
endtask

////////////////////////////////////////
// JAL redirect
////////////////////////////////////////

task automatic jal_redirect();
  logic [XLEN-1:0] jal_pc;
  logic [XLEN-1:0] target;
  jal_pc = 32'h100;
  target = jal_pc + 32'h40;
  mem[jal_pc[9:2]] = jal_word(5'd1, 21'h40);
  flush_to(jal_pc);
  // Target goes out in the cycle the JAL sits in fetch
  next_cycle();
  #1;
  check_pc("jal target address", target, imem_adr_o);
  next_cycle();
  #1;
  check_stage("jal in decode", jal_pc);
  check_pred("jal prediction", 2'b10, pd_bp_predict_o);
  next_cycle();
  #1;
  check_flag("jal single bubble", 1'b1, pd_bubble_o);
  next_cycle();
  #1;
  check_stage("jal target word", target);
endtask

////////////////////////////////////////
// Branch table training
////////////////////////////////////////

task automatic bht_training();
  logic [XLEN-1:0] br_pc;
  logic [XLEN-1:0] target;
  br_pc  = 32'h300;
  target = br_pc - 32'h40;
  mem[br_pc[9:2]] = branch_word(5'd2, 5'd3, 13'h1fc0);
  // Zero history selects a weakly not taken entry
  flush_to(br_pc);
  next_cycle();
  #1;
  check_pc("branch fall-through", br_pc + 32'd4, imem_adr_o);
  next_cycle();
  #1;
  check_stage("untrained branch", br_pc);
  check_pred("untrained prediction", 2'b01, pd_bp_predict_o);
  check_history("untrained history", 2'b00, pd_bp_history_o);
  // Index is pc[7:2]=0 xor history
  // Histories 00 01 11 11 leave entry 3 with the last two updates
  for (int n = 0; n < 4; n++) begin
    next_cycle();
    bht_upd_valid_i = 1'b1;
    bht_upd_pc_i    = br_pc;
    bht_upd_taken_i = 1'b1;
  end
  next_cycle();
  bht_upd_valid_i = 1'b0;
  // Lookup with history 11 hits the saturated entry
  flush_to(br_pc);
  next_cycle();
  #1;
  check_pc("trained branch target", target, imem_adr_o);
  next_cycle();
  #1;
  check_stage("trained branch", br_pc);
  check_pred("trained prediction", 2'b11, pd_bp_predict_o);
  check_history("trained history", 2'b11, pd_bp_history_o);
endtask

////////////////////////////////////////
// Flush priority and alignment
////////////////////////////////////////

task automatic flush_priority();
  next_cycle();
  st_flush_i  = 1'b1;
  st_nxt_pc_i = 32'h243;
  bu_flush_i  = 1'b1;
  bu_nxt_pc_i = 32'h280;
  #1;
  // Store-side flush wins with the low bits masked off
  check_pc("flush priority", 32'h240, imem_adr_o);
  check_flag("flush to decode", 1'b1, pd_flush_o);
  next_cycle();
  st_flush_i = 1'b0;
  bu_flush_i = 1'b0;
  #1;
  check_flag("flush bubble", 1'b1, pd_bubble_o);
  check_flag("flush released", 1'b0, pd_flush_o);
  next_cycle();
  next_cycle();
  #1;
  check_stage("flush target word", 32'h240);
endtask

////////////////////////////////////////
// Stall and exception
////////////////////////////////////////

task automatic stall_and_exception();
  logic [XLEN-1:0] jal_pc;
  logic [XLEN-1:0] target;
  logic [XLEN-1:0] prev_pc;
  jal_pc  = 32'h100;
  target  = jal_pc + 32'h40;
  prev_pc = jal_pc - 32'd4;
  flush_to(prev_pc);
  next_cycle();
  // Decode stalls on prev_pc while the JAL waits in fetch
  for (int n = 0; n < 3; n++) begin
    next_cycle();
    id_stall_i = 1'b1;
    #1;
    check_pc("stall holds fetch", jal_pc, imem_adr_o);
    check_fields("stall holds fields", mem_word(jal_pc));
    check_pc("stall holds pc", prev_pc, pd_pc_o);
    check_insn("stall holds word", mem_word(prev_pc), pd_insn_o);
    check_flag("stall holds valid", 1'b0, pd_bubble_o);
    check_pred("stall holds prediction", 2'b00, pd_bp_predict_o);
  end
  next_cycle();
  id_stall_i = 1'b0;
  #1;
  check_pc("jal after stall", target, imem_adr_o);
  next_cycle();
  #1;
  check_pc("target re-presented", target, imem_adr_o);
  check_stage("jal leaves stall", jal_pc);
  next_cycle();
  #1;
  // A second strobe would hold the address here
  check_pc("single redirect", target + 32'd4, imem_adr_o);
  check_flag("bubble after stalled jal", 1'b1, pd_bubble_o);
  next_cycle();
  pipe_exception_i = 1'b1;
  #1;
  check_stage("target before exception", target);
  next_cycle();
  pipe_exception_i = 1'b0;
  #1;
  check_flag("exception bubble", 1'b1, pd_bubble_o);
  check_pc("exception keeps pc flow", target + 32'd4, pd_pc_o);
endtask

`endif

/* bench/fe_tb.sv */
/* Directed testbench for the instruction front end with a one-cycle memory
   model. Run through the file list; the test tasks come from a header. */
`timescale 1ns/1ps

module fe_tb import fe_pkg::*; ();

  localparam logic [XLEN-1:0] RESET_PC  = 32'h200;
  localparam int              MEM_WORDS = 256;
  localparam int              NUM_TESTS = 5;
  // Twenty cycles per test plus a margin for reset
  localparam int              WATCHDOG_CYCLES = NUM_TESTS * 20 + 20;
  localparam logic [31:0]     LFSR_TAPS = 32'h8020_0003;

  logic                    clk_i;
  logic                    rst_ni;
  logic [XLEN-1:0]         imem_rdata_i = INSTR_NOP;
  logic                    id_stall_i;
  logic                    st_flush_i;
  logic [XLEN-1:0]         st_nxt_pc_i;
  logic                    bu_flush_i;
  logic [XLEN-1:0]         bu_nxt_pc_i;
  logic                    pipe_exception_i;
  logic                    bht_upd_valid_i;
  logic [XLEN-1:0]         bht_upd_pc_i;
  logic                    bht_upd_taken_i;
  logic [XLEN-1:0]         imem_adr_o;
  logic                    pd_flush_o;
  logic [XLEN-1:0]         pd_pc_o;
  insn_u                   pd_insn_o;
  logic                    pd_bubble_o;
  logic [REG_AW-1:0]       pd_rs1_o;
  logic [REG_AW-1:0]       pd_rs2_o;
  logic [CSR_AW-1:0]       pd_csr_reg_o;
  logic [1:0]              pd_bp_predict_o;
  logic [1:0]              pd_bp_history_o;

  logic [XLEN-1:0] mem [MEM_WORDS];
  logic [XLEN-1:0] adr_seen = '0;
  logic [31:0]     lfsr_state = 32'h6bb1;
  int              errors = 0;
  int              checks = 0;

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  fe_top DUT (.*);

  ////////////////////////////////////////
  // Instruction memory model
  ////////////////////////////////////////

  // Address taken at the edge and word returned one cycle later
  always @(posedge clk_i) begin
    adr_seen <= imem_adr_o;
  end

  always @(negedge clk_i) begin
    imem_rdata_i <= mem[adr_seen[9:2]];
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk_i);
    $display("Watchdog expired after %0d cycles, tests did not finish", WATCHDOG_CYCLES);
    $display("Errors found");
    $finish;
  end

  ////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////

  // Galois LFSR stepped once per bit taken
  function automatic logic [31:0] lfsr_bits(input int n);
    logic [31:0] val;
    val = '0;
    for (int b = 0; b < n; b++) begin
      val        = {val[30:0], lfsr_state[0]};
      lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ LFSR_TAPS : lfsr_state >> 1;
    end
    return val;
  endfunction

  // ADDI with random registers and the address as immediate
  function automatic logic [XLEN-1:0] filler_word(input logic [XLEN-1:0] addr);
    logic [REG_AW-1:0] rd;
    logic [REG_AW-1:0] rs1;
    rd  = REG_AW'(lfsr_bits(REG_AW));
    rs1 = REG_AW'(lfsr_bits(REG_AW));
    return {addr[11:0], rs1, 3'b000, rd, 7'b0010011};
  endfunction

  // RISC-V J-type encoding
  function automatic logic [XLEN-1:0] jal_word(input logic [4:0] rd, input logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
  endfunction

  // BEQ in RISC-V B-type encoding
  function automatic logic [XLEN-1:0] branch_word(input logic [4:0] rs1, input logic [4:0] rs2,
                                                  input logic [12:0] off);
    return {off[12], off[10:5], rs2, rs1, 3'b000, off[4:1], off[11], OPC_BRANCH};
  endfunction

  function automatic logic [XLEN-1:0] mem_word(input logic [XLEN-1:0] addr);
    return mem[addr[9:2]];
  endfunction

  task automatic next_cycle();
    @(negedge clk_i);
  endtask

  // One-cycle fetch flush that returns in the re-fetch cycle
  task automatic flush_to(input logic [XLEN-1:0] target);
    next_cycle();
    st_flush_i  = 1'b1;
    st_nxt_pc_i = target;
    next_cycle();
    st_flush_i  = 1'b0;
  endtask

  ////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////

  task automatic check_pc(input string name, input logic [XLEN-1:0] exp,
                          input logic [XLEN-1:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("FAILED %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_insn(input string name, input insn_u exp, input insn_u act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("FAILED %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_pred(input string name, input logic [1:0] exp, input logic [1:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("FAILED %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  task automatic check_history(input string name, input logic [1:0] exp,
                               input logic [1:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("FAILED %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("FAILED %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  task automatic check_reg(input string name, input logic [REG_AW-1:0] exp,
                           input logic [REG_AW-1:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("FAILED %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_csr(input string name, input logic [CSR_AW-1:0] exp,
                           input logic [CSR_AW-1:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("FAILED %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  // Valid word from addr sitting in the decode register
  task automatic check_stage(input string name, input logic [XLEN-1:0] addr);
    insn_u exp_word;
    exp_word = mem_word(addr);
    check_pc({name, " pc"}, addr, pd_pc_o);
    check_insn({name, " word"}, exp_word, pd_insn_o);
    check_flag({name, " bubble"}, 1'b0, pd_bubble_o);
  endtask

  // Operand fields of the word now in fetch
  task automatic check_fields(input string name, input logic [XLEN-1:0] word);
    check_reg({name, " rs1"}, word[19:15], pd_rs1_o);
    check_reg({name, " rs2"}, word[24:20], pd_rs2_o);
    check_csr({name, " csr"}, word[31:20], pd_csr_reg_o);
  endtask

  `include "fe_tb_tests.svh"

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////

  initial begin
    rst_ni           = 1'b0;
    id_stall_i       = 1'b0;
    st_flush_i       = 1'b0;
    st_nxt_pc_i      = '0;
    bu_flush_i       = 1'b0;
    bu_nxt_pc_i      = '0;
    pipe_exception_i = 1'b0;
    bht_upd_valid_i  = 1'b0;
    bht_upd_pc_i     = '0;
    bht_upd_taken_i  = 1'b0;
    for (int a = 0; a < MEM_WORDS; a++) begin
      mem[a] = filler_word(XLEN'(a * 4));
    end
    repeat (4) @(negedge clk_i);
    rst_ni = 1'b1;
    sequential_fetch();
    jal_redirect();
    bht_training();
    flush_priority();
    stall_and_exception();
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

/* src.f */
+incdir+include
logic/fe_pkg.sv
logic/fe_pc_gen.sv
logic/fe_bht.sv
logic/fe_predecode.sv
logic/fe_top.sv
bench/fe_tb.sv

/* sim.sh */
#!/bin/sh
# Builds the front-end testbench with Verilator and runs it once
cd "$(dirname "$0")" &&
verilator --binary --timing -f src.f --top-module fe_tb -o fe_tb_sim &&
out="$(./obj_dir/fe_tb_sim)" &&
printf '%s\n' "$out" &&
printf '%s\n' "$out" | grep -qx "No errors" &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }
